// ==== Bender.yml ====
package:
  name: hps_io

sources:
  - src/hps_cmd_pkg.sv
  - src/ps2_pkg.sv
  - src/host_cmd_decoder.sv
  - src/file_loader.sv
  - src/scancode_decoder.sv
  - src/ps2_kbd_tx.sv
  - src/hps_io_top.sv
  - target: test
    files:
      - sim/hps_io_assertions.sv
      - sim/tb_hps_io.sv

// ==== compile.f ====
src/hps_cmd_pkg.sv
src/ps2_pkg.sv
src/host_cmd_decoder.sv
src/file_loader.sv
src/scancode_decoder.sv
src/ps2_kbd_tx.sv
src/hps_io_top.sv
sim/hps_io_assertions.sv
sim/tb_hps_io.sv

// ==== sim/hps_io_assertions.sv ====
// bridge protocol assertions
// bound to the top level, watches the download write pulse and read data

`timescale 1ns/1ns

module hps_io_assertions (
	input logic        clk_sys,
	input logic        arst_n,
	input logic        io_enable,
	input logic [15:0] io_dout,
	input logic        ioctl_wr,
	input logic        ioctl_download
);

	// number of failed assertions
	int err_cnt = 0;

	// write strobe is a single cycle pulse
	assert property (@(posedge clk_sys) disable iff (!arst_n) ioctl_wr |=> !ioctl_wr)
		else begin
			err_cnt++;
			$error("ioctl_wr high for two cycles");
		end

	assert property (@(posedge clk_sys) disable iff (!arst_n) ioctl_wr |-> ioctl_download)
		else begin
			err_cnt++;
			$error("ioctl_wr outside a download");
		end

	// read bus goes quiet once the frame is closed
	assert property (@(posedge clk_sys) disable iff (!arst_n) !io_enable |=> io_dout == '0)
		else begin
			err_cnt++;
			$error("io_dout not zero outside a frame");
		end

endmodule

bind hps_io_top hps_io_assertions u_hps_io_assertions (
	.clk_sys(clk_sys),
	.arst_n(arst_n),
	.io_enable(io_enable),
	.io_dout(io_dout),
	.ioctl_wr(ioctl_wr),
	.ioctl_download(ioctl_download)
);

// ==== sim/tb_hps_io.sv ====
// testbench for the host command bridge
// runs register, readback, keyboard, ps/2 serial and download transactions
// and compares the results with values computed from the bus rules

`timescale 1ns/1ns

module tb_hps_io
	import hps_cmd_pkg::*;
	import ps2_pkg::*;
;

	localparam int CLK_PERIOD   = 40;
	localparam int PS2DIV       = 3;
	localparam int FRAME_CYCLES = 2 * (PS2DIV + 1) * (PS2_START_GAP + 12);
	localparam int KEY_SEQS     = 12;
	localparam int PS2_BURST    = 6;
	localparam int DAT_WORDS    = 16;
	localparam int KBD_BYTES    = KEY_SEQS * 3 + 12 + 3 + PS2_BURST;
	localparam int BUS_CYCLES   = 2000;
	localparam longint WATCHDOG_NS =
		2 * (KBD_BYTES * FRAME_CYCLES + BUS_CYCLES) * CLK_PERIOD;

	logic        clk_sys;
	logic        arst_n;
	logic        io_enable;
	logic        io_strobe;
	logic [15:0] io_din;
	logic [15:0] io_dout;
	logic        io_wait;
	logic        ioctl_wait;
	logic [31:0] status_in;
	logic        status_set;
	logic [2:0]  kbd_led_status;
	logic [2:0]  kbd_led_use;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	logic [15:0] joystick_0;
	logic [15:0] joystick_1;
	logic [31:0] status;
	logic [10:0] ps2_key;
	logic        ps2_kbd_clk_out;
	logic        ps2_kbd_data_out;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic [31:0] ioctl_file_ext;

	logic [15:0] tx_q [$];
	logic [15:0] rx_q [$];
	logic [7:0]  key_q [$];
	logic [7:0]  kbd_exp [$];
	logic [15:0] dat_exp [$];
	int          wr_cnt;

	hps_io_top #(
		.WIDE(1),
		.PS2DIV(PS2DIV),
		.FIFO_BITS(5)
	) u_hps_io_top (
		.clk_sys, .arst_n,
		.io_enable, .io_strobe, .io_din, .io_dout, .io_wait, .ioctl_wait,
		.status_in, .status_set, .kbd_led_status, .kbd_led_use,
		.buttons, .forced_scandoubler, .joystick_0, .joystick_1, .status,
		.ps2_key, .ps2_kbd_clk_out, .ps2_kbd_data_out,
		.ioctl_download, .ioctl_index, .ioctl_wr,
		.ioctl_addr, .ioctl_dout, .ioctl_file_ext
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("FAIL %0t: %s, got %0h expected %0h", $time, what, actual, expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// event word from the last four bytes of a keyboard frame
	function automatic logic [10:0] ref_key(input logic [31:0] raw, input logic tog);
		logic pressed;
		logic extended;
		if (raw == 32'hE012E07C)
			return {~tog, 10'h37C};
		if (raw == 32'h7CE0F012)
			return {~tog, 10'h17C};
		if (raw == 32'hF014F077)
			return {~tog, 10'h377};
		pressed  = (raw[15:8] != 8'hF0);
		extended = pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);
		return {~tog, pressed, extended, raw[7:0]};
	endfunction

	// frame bits in wire order: start, data lsb first, odd parity, stop
	function automatic logic [10:0] ref_frame(input logic [7:0] b);
		return {1'b1, ~^b, b, 1'b0};
	endfunction

	// one host transaction from tx_q, answers collected in rx_q
	task automatic run_frame();
		int i;
		rx_q.delete();
		for (i = 0; i < tx_q.size(); i++) begin
			@(negedge clk_sys);
			while (io_wait)
				@(negedge clk_sys);
			io_enable = 1'b1;
			io_strobe = 1'b1;
			io_din    = tx_q[i];
			if (i > 0 && tx_q[0] == CMD_KBD)
				kbd_exp.push_back(tx_q[i][7:0]);
			@(negedge clk_sys);
			io_strobe = 1'b0;
			rx_q.push_back(io_dout);
		end
		io_enable = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic send_keys();
		logic [31:0] raw;
		logic [10:0] expected;
		int          i;
		raw = '0;
		// keep the transmitter fifo well below its depth
		while (kbd_exp.size() > 16)
			@(negedge clk_sys);
		tx_q = {CMD_KBD};
		for (i = 0; i < key_q.size(); i++) begin
			tx_q.push_back({8'h00, key_q[i]});
			raw = {raw[23:0], key_q[i]};
		end
		expected = ref_key(raw, ps2_key[10]);
		run_frame();
		check(ps2_key, expected, "ps2_key event");
	endtask

	task automatic wait_ps2_idle();
		while (kbd_exp.size() != 0)
			@(negedge clk_sys);
		repeat (4 * (PS2DIV + 1)) @(negedge clk_sys);
		check(ps2_kbd_clk_out, 1'b1, "ps2 clock idle");
		check(ps2_kbd_data_out, 1'b1, "ps2 data idle");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// monitors
	initial begin
		logic [10:0] bits;
		int          i;
		wait (arst_n);
		forever begin
			for (i = 0; i < 11; i++) begin
				@(negedge ps2_kbd_clk_out);
				bits[i] = ps2_kbd_data_out;
			end
			check(kbd_exp.size() != 0, 1'b1, "ps2 frame without a queued byte");
			check(bits, ref_frame(kbd_exp.pop_front()), "ps2 frame");
			@(posedge ps2_kbd_clk_out);
			@(negedge clk_sys);
			check(ps2_kbd_data_out, 1'b1, "ps2 data after frame");
		end
	end

	always @(negedge clk_sys) begin
		if (arst_n && ioctl_wr) begin
			check(wr_cnt < dat_exp.size(), 1'b1, "unexpected ioctl write");
			check(ioctl_addr, 2 * wr_cnt, "ioctl_addr");
			check(ioctl_dout, dat_exp[wr_cnt], "ioctl_dout");
			wr_cnt++;
		end
	end

	// bound protocol assertions
	always @(negedge clk_sys)
		check(u_hps_io_top.u_hps_io_assertions.err_cnt, 0, "protocol assertion failures");

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog timeout, the run did not finish in time");
		$display("tests failed");
		$fatal(1);
	end

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	initial begin
		int          seed;
		int          n;
		int          k;
		int          total;
		logic [31:0] r;
		logic [31:0] last;
		logic [7:0]  code;
		logic [7:0]  idx;
		seed = 32'hcfec;
		r    = $urandom(seed);
		io_enable      = 1'b0;
		io_strobe      = 1'b0;
		io_din         = '0;
		ioctl_wait     = 1'b0;
		status_in      = '0;
		status_set     = 1'b0;
		kbd_led_status = '0;
		kbd_led_use    = '0;
		wr_cnt         = 0;
		arst_n         = 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1;

		// reset values
		@(negedge clk_sys);
		check({buttons, forced_scandoubler}, '0, "config register");
		check({joystick_0, joystick_1}, '0, "joysticks");
		check(status, '0, "status");
		check({ioctl_wr, ioctl_download, ioctl_index}, '0, "ioctl control");
		check(ioctl_addr, '0, "ioctl_addr at reset");
		check(ioctl_dout, '0, "ioctl_dout at reset");
		check(ioctl_file_ext, '0, "ioctl_file_ext at reset");
		check({io_dout, 5'd0, ps2_key}, '0, "io_dout and ps2_key");
		check({ps2_kbd_clk_out, ps2_kbd_data_out}, 2'b11, "ps2 lines at reset");

		// download back-pressure reaches the host
		ioctl_wait = 1'b1;
		@(negedge clk_sys);
		check(io_wait, 1'b1, "io_wait raised");
		ioctl_wait = 1'b0;
		@(negedge clk_sys);
		check(io_wait, 1'b0, "io_wait released");

		// register writes
		for (n = 0; n < 12; n++) begin
			r = $urandom;
			case (n % 4)
				0: begin
					tx_q = {CMD_CFG, r[15:0]};
					run_frame();
					check(buttons, r[1:0], "buttons");
					check(forced_scandoubler, r[4], "forced_scandoubler");
				end
				1: begin
					tx_q = {CMD_JOY0, r[15:0]};
					run_frame();
					check(joystick_0, r[15:0], "joystick_0");
				end
				2: begin
					tx_q = {CMD_JOY1, r[15:0]};
					run_frame();
					check(joystick_1, r[15:0], "joystick_1");
				end
				default: begin
					tx_q = {CMD_STATUS, r[15:0], r[31:16]};
					run_frame();
					check(status, r, "status");
				end
			endcase
		end

		// status request readback, counter runs past 16
		total = 0;
		last  = '0;
		for (n = 0; n < 4; n++) begin
			k = 5 + $urandom % 3;
			repeat (k) begin
				@(negedge clk_sys);
				last       = $urandom;
				status_in  = last;
				status_set = 1'b1;
				@(negedge clk_sys);
				status_set = 1'b0;
			end
			total += k;
			tx_q = {CMD_STATUS_REQ, 16'h0000, 16'h0000};
			run_frame();
			check(rx_q[0], {8'h00, 4'hA, total[3:0]}, "status request tag");
			check(rx_q[1], last[15:0], "status request low");
			check(rx_q[2], last[31:16], "status request high");
		end

		// keyboard led readback
		for (n = 0; n < 4; n++) begin
			r = $urandom;
			kbd_led_status = r[2:0];
			kbd_led_use    = r[5:3];
			tx_q = {CMD_KBD_LED, 16'h0000};
			run_frame();
			check(rx_q[1], {7'd0, 1'b0, 2'b01, r[2], r[5], r[1], r[4], r[0], r[3]},
				"keyboard led word");
		end

		// keyboard events
		for (n = 0; n < KEY_SEQS; n++) begin
			code = 8'h01 + 8'($urandom % 126);
			case ($urandom % 4)
				0: key_q = {code};
				1: key_q = {8'hE0, code};
				2: key_q = {8'hF0, code};
				default: key_q = {8'hE0, 8'hF0, code};
			endcase
			send_keys();
		end
		key_q = {8'hE0, 8'h12, 8'hE0, 8'h7C};
		send_keys();
		key_q = {8'h7C, 8'hE0, 8'hF0, 8'h12};
		send_keys();
		key_q = {8'hF0, 8'h14, 8'hF0, 8'h77};
		send_keys();
		// marker of all ones hides the frame from the event decoder
		r    = {21'd0, ps2_key};
		tx_q = {CMD_KBD, 16'h0012, 16'hFF34, 16'h0056};
		run_frame();
		check(ps2_key, r[10:0], "ps2_key after skipped frame");
		wait_ps2_idle();

		// ps/2 serial burst, frames checked by the monitor
		tx_q = {CMD_KBD};
		for (n = 0; n < PS2_BURST; n++)
			tx_q.push_back({8'h00, 8'($urandom)});
		run_frame();
		wait_ps2_idle();

		// file download
		idx = $urandom;
		r   = $urandom;
		for (n = 0; n < DAT_WORDS; n++)
			dat_exp.push_back(16'($urandom));
		tx_q = {CMD_FILE_INDEX, {8'h00, idx}};
		run_frame();
		tx_q = {CMD_FILE_INFO, r[31:16], r[15:0]};
		run_frame();
		tx_q = {CMD_FILE_TX, 16'h00FF};
		run_frame();
		check(ioctl_download, 1'b1, "ioctl_download at start");
		tx_q = {CMD_FILE_DAT};
		for (n = 0; n < DAT_WORDS; n++)
			tx_q.push_back(dat_exp[n]);
		run_frame();
		tx_q = {CMD_FILE_TX, 16'h0000};
		run_frame();
		check(wr_cnt, DAT_WORDS, "ioctl write count");
		check(ioctl_download, 1'b0, "ioctl_download at end");
		check(ioctl_addr, 2 * DAT_WORDS, "final ioctl_addr");
		check(ioctl_index, idx, "ioctl_index");
		check(ioctl_file_ext, r, "ioctl_file_ext");

		$display("all tests passed");
		$finish;
	end

endmodule

// ==== src/file_loader.sv ====
// file download port
// decodes the file commands of the host and produces the ioctl write
// stream. in wide mode words are 16 bits and the address steps by 2

`timescale 1ns/1ns

module file_loader
	import hps_cmd_pkg::*;
#(
	parameter int WIDE = 0
) (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic [HOST_WORD_W-1:0] cmd,
	input  logic                   data_stb,
	input  logic [9:0]             word_idx,
	input  host_word_u             io_din,
	output logic                   ioctl_download,
	output logic [7:0]             ioctl_index,
	output logic                   ioctl_wr,
	output logic [24:0]            ioctl_addr,
	output logic [15:0]            ioctl_dout,
	output logic [31:0]            ioctl_file_ext
);

	localparam logic [24:0] ADDR_STEP = (WIDE != 0) ? 25'd2 : 25'd1;

	logic [24:0] addr;
	logic [24:0] wr_addr;
	logic [15:0] wr_data;
	logic [15:0] din_word;
	logic        wr;

	// narrow mode keeps only the low byte
	assign din_word = (WIDE != 0) ? io_din.cmd : {8'h00, io_din.pair.payload};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			ioctl_wr       <= 1'b0;
			wr             <= 1'b0;
			addr           <= '0;
		end else begin
			// address and data move out together with the write pulse
			ioctl_wr <= wr;
			wr       <= 1'b0;
			if (wr) begin
				ioctl_addr <= wr_addr;
				ioctl_dout <= wr_data;
			end
			if (data_stb) begin
				case (cmd)
					CMD_FILE_INFO: begin
						if (word_idx == 10'd1)
							ioctl_file_ext[31:16] <= io_din.cmd;
						else if (word_idx == 10'd2)
							ioctl_file_ext[15:0] <= io_din.cmd;
					end
					CMD_FILE_INDEX: ioctl_index <= io_din.pair.payload;
					CMD_FILE_TX: begin
						if (|io_din.pair.payload) begin
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// end of download shows the final address
							ioctl_addr     <= addr;
							ioctl_download <= 1'b0;
						end
					end
					CMD_FILE_DAT: begin
						wr   <= 1'b1;
						addr <= addr + ADDR_STEP;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (data_stb && (cmd == CMD_FILE_DAT)) begin
			wr_addr <= addr;
			wr_data <= din_word;
		end
	end

endmodule

// ==== src/host_cmd_decoder.sv ====
// host command decoder
// frames host transactions, latches the command word, writes the control
// registers and answers status and keyboard led reads. keyboard bytes are
// forwarded to the event decoder and the ps/2 transmitter

`timescale 1ns/1ns

module host_cmd_decoder
	import hps_cmd_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   io_enable,
	input  logic                   io_strobe,
	input  host_word_u             io_din,
	input  logic [31:0]            status_in,
	input  logic                   status_set,
	input  logic [2:0]             kbd_led_status,
	input  logic [2:0]             kbd_led_use,
	output logic [HOST_WORD_W-1:0] io_dout,
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output logic [15:0]            joystick_0,
	output logic [15:0]            joystick_1,
	output logic [31:0]            status,
	output logic [HOST_WORD_W-1:0] cmd,
	output logic                   data_stb,
	output logic [9:0]             word_idx,
	output logic                   key_clear,
	output logic [7:0]             key_byte,
	output logic                   key_we,
	output logic                   key_done,
	output logic [7:0]             kbd_byte,
	output logic                   kbd_we
);

	logic        cmd_stb;
	logic        old_enable;
	logic        frame_end;
	logic        skip_marker;
	logic        ps2skip;
	logic        old_status_set;
	logic [3:0]  stflg;
	logic [31:0] status_req;
	logic [8:0]  led_word;

	// word 0 of a frame is the command, every later word is data
	assign cmd_stb     = io_enable & io_strobe & (word_idx == '0);
	assign data_stb    = io_enable & io_strobe & (word_idx != '0);
	assign frame_end   = old_enable & ~io_enable;
	assign skip_marker = &io_din.pair.marker;
	assign key_byte    = kbd_byte;

	// led readback, bit 2 pair first
	assign led_word = {1'b0, 2'b01,
		kbd_led_status[2], kbd_led_use[2],
		kbd_led_status[1], kbd_led_use[1],
		kbd_led_status[0], kbd_led_use[0]};

	////////////////////////////////////////////////////////////////////////////
	// framing
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			old_enable <= 1'b0;
			word_idx   <= '0;
			cmd        <= '0;
		end else begin
			old_enable <= io_enable;
			if (!io_enable) begin
				word_idx <= '0;
				cmd      <= '0;
			end else if (io_strobe) begin
				// saturate so long downloads keep a nonzero index
				if (~&word_idx)
					word_idx <= word_idx + 1'b1;
				if (cmd_stb)
					cmd <= io_din.cmd;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// register writes
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			buttons            <= '0;
			forced_scandoubler <= 1'b0;
			joystick_0         <= '0;
			joystick_1         <= '0;
			status             <= '0;
		end else if (data_stb) begin
			case (cmd)
				CMD_CFG: begin
					buttons            <= io_din.pair.payload[1:0];
					forced_scandoubler <= io_din.pair.payload[4];
				end
				CMD_JOY0: joystick_0 <= io_din.cmd;
				CMD_JOY1: joystick_1 <= io_din.cmd;
				CMD_STATUS: begin
					if (word_idx == 10'd1)
						status[15:0] <= io_din.cmd;
					else if (word_idx == 10'd2)
						status[31:16] <= io_din.cmd;
				end
				default: ;
			endcase
		end
	end

	// status request from the core, counted on each rising edge
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			old_status_set <= 1'b0;
			stflg          <= '0;
			status_req     <= '0;
		end else begin
			old_status_set <= status_set;
			if (status_set && !old_status_set) begin
				stflg      <= stflg + 1'b1;
				status_req <= status_in;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// keyboard bytes
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ps2skip   <= 1'b0;
			key_clear <= 1'b0;
			key_we    <= 1'b0;
			kbd_we    <= 1'b0;
			key_done  <= 1'b0;
		end else begin
			key_clear <= cmd_stb && (io_din.cmd == CMD_KBD);
			key_we    <= 1'b0;
			kbd_we    <= 1'b0;
			// frame closes with cmd and skip flag still valid this cycle
			key_done  <= frame_end && (cmd == CMD_KBD) && !ps2skip;
			if (!io_enable) begin
				ps2skip <= 1'b0;
			end else if (data_stb && (cmd == CMD_KBD)) begin
				kbd_we <= 1'b1;
				key_we <= !skip_marker && !ps2skip;
				if (skip_marker)
					ps2skip <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (data_stb && (cmd == CMD_KBD))
			kbd_byte <= io_din.pair.payload;
	end

	////////////////////////////////////////////////////////////////////////////
	// read data, held until the next strobe
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			io_dout <= '0;
		end else if (!io_enable) begin
			io_dout <= '0;
		end else if (io_strobe) begin
			io_dout <= '0;
			if (cmd_stb) begin
				if (io_din.cmd == CMD_STATUS_REQ)
					io_dout <= {8'h00, STATUS_REQ_TAG, stflg};
			end else begin
				case (cmd)
					CMD_STATUS_REQ: begin
						if (word_idx == 10'd1)
							io_dout <= status_req[15:0];
						else if (word_idx == 10'd2)
							io_dout <= status_req[31:16];
					end
					CMD_KBD_LED: io_dout <= {7'd0, led_word};
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== src/hps_cmd_pkg.sv ====
// host command definitions
// opcodes of the host word bus and the two ways a host word is decoded

package hps_cmd_pkg;

	localparam int HOST_WORD_W = 16;

	// a host word is either a full opcode or a marker/payload byte pair
	typedef struct packed {
		logic [7:0] marker;
		logic [7:0] payload;
	} host_pair_t;

	typedef union packed {
		logic [HOST_WORD_W-1:0] cmd;
		host_pair_t             pair;
	} host_word_u;

	////////////////////////////////////////////////////////////////////////////
	// opcodes
	localparam logic [HOST_WORD_W-1:0] CMD_CFG        = 16'h0001;
	localparam logic [HOST_WORD_W-1:0] CMD_JOY0       = 16'h0002;
	localparam logic [HOST_WORD_W-1:0] CMD_JOY1       = 16'h0003;
	localparam logic [HOST_WORD_W-1:0] CMD_KBD        = 16'h0005;
	localparam logic [HOST_WORD_W-1:0] CMD_STATUS     = 16'h001E;
	localparam logic [HOST_WORD_W-1:0] CMD_KBD_LED    = 16'h001F;
	localparam logic [HOST_WORD_W-1:0] CMD_STATUS_REQ = 16'h0029;
	localparam logic [HOST_WORD_W-1:0] CMD_FILE_TX    = 16'h0053;
	localparam logic [HOST_WORD_W-1:0] CMD_FILE_DAT   = 16'h0054;
	localparam logic [HOST_WORD_W-1:0] CMD_FILE_INDEX = 16'h0055;
	localparam logic [HOST_WORD_W-1:0] CMD_FILE_INFO  = 16'h0056;

	// upper nibble of the first status request answer
	localparam logic [3:0] STATUS_REQ_TAG = 4'hA;

endpackage

// ==== src/hps_io_top.sv ====
// host command bridge
// connects the host word bus to the control registers, the keyboard
// event decoder, the ps/2 keyboard transmitter and the file download port

`timescale 1ns/1ns

module hps_io_top
	import hps_cmd_pkg::*;
#(
	parameter int WIDE      = 0,
	parameter int PS2DIV    = 2000,
	parameter int FIFO_BITS = 5
) (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	// host bus
	input  logic                   io_enable,
	input  logic                   io_strobe,
	input  host_word_u             io_din,
	output logic [HOST_WORD_W-1:0] io_dout,
	output logic                   io_wait,
	input  logic                   ioctl_wait,
	// control registers
	input  logic [31:0]            status_in,
	input  logic                   status_set,
	input  logic [2:0]             kbd_led_status,
	input  logic [2:0]             kbd_led_use,
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output logic [15:0]            joystick_0,
	output logic [15:0]            joystick_1,
	output logic [31:0]            status,
	// keyboard
	output logic [10:0]            ps2_key,
	output logic                   ps2_kbd_clk_out,
	output logic                   ps2_kbd_data_out,
	// download
	output logic                   ioctl_download,
	output logic [7:0]             ioctl_index,
	output logic                   ioctl_wr,
	output logic [24:0]            ioctl_addr,
	output logic [15:0]            ioctl_dout,
	output logic [31:0]            ioctl_file_ext
);

	logic [HOST_WORD_W-1:0] cmd;
	logic                   data_stb;
	logic [9:0]             word_idx;
	logic                   key_clear;
	logic [7:0]             key_byte;
	logic                   key_we;
	logic                   key_done;
	logic [7:0]             kbd_byte;
	logic                   kbd_we;

	// download back-pressure goes straight to the host
	assign io_wait = ioctl_wait;

	host_cmd_decoder u_host_cmd_decoder (
		.clk_sys, .arst_n,
		.io_enable, .io_strobe, .io_din, .io_dout,
		.status_in, .status_set, .kbd_led_status, .kbd_led_use,
		.buttons, .forced_scandoubler, .joystick_0, .joystick_1, .status,
		.cmd, .data_stb, .word_idx,
		.key_clear, .key_byte, .key_we, .key_done,
		.kbd_byte, .kbd_we
	);

	file_loader #(
		.WIDE(WIDE)
	) u_file_loader (
		.clk_sys, .arst_n,
		.cmd, .data_stb, .word_idx, .io_din,
		.ioctl_download, .ioctl_index, .ioctl_wr,
		.ioctl_addr, .ioctl_dout, .ioctl_file_ext
	);

	scancode_decoder u_scancode_decoder (
		.clk_sys, .arst_n,
		.key_clear, .key_byte, .key_we, .key_done,
		.ps2_key
	);

	ps2_kbd_tx #(
		.PS2DIV(PS2DIV),
		.FIFO_BITS(FIFO_BITS)
	) u_ps2_kbd_tx (
		.clk_sys, .arst_n,
		.kbd_byte, .kbd_we,
		.ps2_kbd_clk_out, .ps2_kbd_data_out
	);

endmodule

// ==== src/ps2_kbd_tx.sv ====
// ps/2 keyboard transmitter
// divides clk_sys down to the ps/2 clock, buffers bytes in a fifo and
// sends each one as an 11 bit frame, lsb first with odd parity.
// data changes on the rising tick and is stable on the falling clock edge

`timescale 1ns/1ns

module ps2_kbd_tx
	import ps2_pkg::*;
#(
	parameter int PS2DIV    = 2000,
	parameter int FIFO_BITS = 5
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic [7:0] kbd_byte,
	input  logic       kbd_we,
	output logic       ps2_kbd_clk_out,
	output logic       ps2_kbd_data_out
);

	localparam int DIV_W = $clog2(PS2DIV + 2);
	localparam int GAP_W = $clog2(PS2_START_GAP + 1);

	logic [7:0]           fifo_mem [2**FIFO_BITS];
	logic [FIFO_BITS-1:0] wptr;
	logic [FIFO_BITS-1:0] rptr;
	logic [DIV_W-1:0]     div_cnt;
	logic                 clk_ps2;
	logic                 old_clk;
	logic                 tick_rise;
	logic                 tick_fall;
	logic                 fifo_empty;
	logic [GAP_W-1:0]     gap;
	logic [3:0]           tx_state;
	logic [7:0]           tx_byte;
	logic                 parity;
	logic                 tx_start;
	logic                 tx_shift;

	assign tick_rise  = clk_ps2 & ~old_clk;
	assign tick_fall  = ~clk_ps2 & old_clk;
	assign fifo_empty = (wptr == rptr);
	assign tx_start   = tick_rise && (tx_state == '0) && !fifo_empty &&
		(gap == GAP_W'(PS2_START_GAP));
	// states 1 to 8 carry the data bits
	assign tx_shift   = tick_rise && (tx_state >= 4'd1) && (tx_state <= 4'd8);

	always_ff @(posedge clk_sys) begin
		if (kbd_we)
			fifo_mem[wptr] <= kbd_byte;
		if (tx_start)
			tx_byte <= fifo_mem[rptr];
		else if (tx_shift)
			tx_byte <= {1'b0, tx_byte[7:1]};
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt          <= '0;
			clk_ps2          <= 1'b0;
			old_clk          <= 1'b0;
			wptr             <= '0;
			rptr             <= '0;
			gap              <= '0;
			tx_state         <= '0;
			parity           <= 1'b1;
			ps2_kbd_clk_out  <= 1'b1;
			ps2_kbd_data_out <= 1'b1;
		end else begin
			// ps/2 tick
			if (div_cnt == DIV_W'(PS2DIV)) begin
				div_cnt <= '0;
				clk_ps2 <= ~clk_ps2;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			old_clk <= clk_ps2;

			// a full fifo wraps and overwrites
			if (kbd_we)
				wptr <= wptr + 1'b1;

			if (tick_rise) begin
				ps2_kbd_clk_out <= 1'b1;
				if (tx_state == '0) begin
					if (tx_start) begin
						rptr             <= rptr + 1'b1;
						gap              <= '0;
						parity           <= 1'b1;
						tx_state         <= 4'd1;
						ps2_kbd_data_out <= 1'b0;
					end else if (!fifo_empty) begin
						gap <= gap + 1'b1;
					end
				end else begin
					if (tx_shift) begin
						ps2_kbd_data_out <= tx_byte[0];
						if (tx_byte[0])
							parity <= ~parity;
					end else if (tx_state == 4'd9) begin
						ps2_kbd_data_out <= parity;
					end else begin
						// stop bit, and idle level afterwards
						ps2_kbd_data_out <= 1'b1;
					end
					tx_state <= (tx_state == PS2_TX_LAST) ? 4'd0 : tx_state + 1'b1;
				end
			end

			// clock only pulses low while a frame is on the wire
			if (tick_fall)
				ps2_kbd_clk_out <= (tx_state == '0);
		end
	end

endmodule

// ==== src/ps2_pkg.sv ====
// ps/2 keyboard definitions
// scancode prefixes, special key sequences and serial frame timing

package ps2_pkg;

	// scancode prefixes
	localparam logic [7:0] PS2_BREAK = 8'hF0;
	localparam logic [7:0] PS2_EXT   = 8'hE0;

	// raw sequences that get a dedicated event code
	localparam logic [31:0] KEY_PRNSCR_MAKE  = 32'hE012E07C;
	localparam logic [31:0] KEY_PRNSCR_BREAK = 32'h7CE0F012;
	localparam logic [31:0] KEY_PAUSE_MAKE   = 32'hF014F077;
	localparam logic [9:0]  EV_PRNSCR_MAKE   = 10'h37C;
	localparam logic [9:0]  EV_PRNSCR_BREAK  = 10'h17C;
	localparam logic [9:0]  EV_PAUSE         = 10'h377;

	// transmitter steps: start, 8 data, parity, stop, then back to idle
	localparam logic [3:0] PS2_TX_LAST   = 4'd11;
	localparam int         PS2_START_GAP = 4;

endpackage

// ==== src/scancode_decoder.sv ====
// keyboard event decoder
// collects the scancode bytes of one keyboard transaction and turns them
// into the ps2_key event word: [10] toggle, [9] pressed, [8] extended

`timescale 1ns/1ns

module scancode_decoder
	import ps2_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        key_clear,
	input  logic [7:0]  key_byte,
	input  logic        key_we,
	input  logic        key_done,
	output logic [10:0] ps2_key
);

	logic [31:0] raw;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_event;

	assign pressed  = (raw[15:8] != PS2_BREAK);
	// a break code pushes the e0 prefix one byte further back
	assign extended = pressed ? (raw[15:8] == PS2_EXT) : (raw[23:16] == PS2_EXT);

	always_comb begin
		case (raw)
			KEY_PRNSCR_MAKE:  key_event = EV_PRNSCR_MAKE;
			KEY_PRNSCR_BREAK: key_event = EV_PRNSCR_BREAK;
			KEY_PAUSE_MAKE:   key_event = EV_PAUSE;
			default:          key_event = {pressed, extended, raw[7:0]};
		endcase
	end

	// byte history, newest byte lowest
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			raw <= '0;
		else if (key_clear)
			raw <= '0;
		else if (key_we)
			raw <= {raw[23:0], key_byte};
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			ps2_key <= '0;
		else if (key_done)
			ps2_key <= {~ps2_key[10], key_event};
	end

endmodule
